// ==== design/dmem_pkg.sv ====
/* geometry, widths and bus types shared by the data-memory subsystem
   every design file imports what it needs from here */
package dmem_pkg;

    localparam int ADDR_W     = 64;
    localparam int LINE_BYTES = 32;
    localparam int LINE_W     = LINE_BYTES * 8;
    localparam int WAYS       = 4;
    localparam int SETS       = 8;
    localparam int OFFS_W     = $clog2(LINE_BYTES);
    localparam int SET_W      = $clog2(SETS);
    localparam int WAY_W      = $clog2(WAYS);
    localparam int L2_LINES   = 1024;
    localparam int BLK_W      = $clog2(L2_LINES);
    // address bits above the backing memory are ignored
    localparam int TAG_W      = BLK_W - SET_W;
    localparam int L2_LATENCY = 4;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LINE_W-1:0] line_t;
    typedef logic [BLK_W-1:0]  blk_addr_t;
    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [SET_W-1:0]  set_t;
    typedef logic [WAY_W-1:0]  way_t;
    typedef logic [OFFS_W-1:0] offs_t;
    // bit 2 unsigned, bits 1:0 log2 of the size in bytes
    typedef logic [2:0]        acc_len_t;

    typedef struct packed {
        addr_t       addr;
        acc_len_t    len;
        logic [63:0] wdata;
        logic        wr;
    } mem_req_t;

    typedef struct packed {
        logic [63:0] rdata;
        logic        ld_ma;
        logic        st_ma;
    } mem_resp_t;

    typedef struct packed {
        blk_addr_t blk;
        logic      wr;
        line_t     wline;
    } line_req_t;

    typedef enum logic [2:0] {
        S_READY,
        S_LOOKUP,
        S_FETCH,
        S_FILL,
        S_RESP
    } cache_state_e;

endpackage

// ==== design/dmem_align.sv ====
/* byte lane handling between a cache line and a 64-bit access
   merges store data into the line, extracts and extends load data,
   and flags accesses whose offset is not a multiple of their size */
module dmem_align (
    input  dmem_pkg::mem_req_t req,
    input  dmem_pkg::line_t    line,
    output dmem_pkg::line_t    merged,
    output logic [63:0]        rdata,
    output logic               ld_ma,
    output logic               st_ma
);
    import dmem_pkg::*;

    offs_t       offs;
    logic [7:0]  shamt;
    logic [63:0] lane_mask;
    logic        ma;
    line_t       field_mask;
    line_t       shifted;
    logic [63:0] raw;

    assign offs  = req.addr[OFFS_W-1:0];
    assign shamt = {offs, 3'b000};

    // low offset bits must be zero for the access size
    always_comb begin
        case (req.len[1:0])
            2'd0:    ma = 1'b0;
            2'd1:    ma = offs[0];
            2'd2:    ma = |offs[1:0];
            default: ma = |offs[2:0];
        endcase
    end

    assign ld_ma = ma & ~req.wr;
    assign st_ma = ma & req.wr;

    always_comb begin
        case (req.len[1:0])
            2'd0:    lane_mask = 64'h0000_0000_0000_00ff;
            2'd1:    lane_mask = 64'h0000_0000_0000_ffff;
            2'd2:    lane_mask = 64'h0000_0000_ffff_ffff;
            default: lane_mask = 64'hffff_ffff_ffff_ffff;
        endcase
    end

    // store overlay
    assign field_mask = line_t'(lane_mask) << shamt;
    assign merged     = (line & ~field_mask) | (line_t'(req.wdata & lane_mask) << shamt);

    // load field sits in the low bits after the shift
    assign shifted = line >> shamt;
    assign raw     = shifted[63:0];

    always_comb begin
        case (req.len)
            3'b000:  rdata = {{56{raw[7]}}, raw[7:0]};
            3'b001:  rdata = {{48{raw[15]}}, raw[15:0]};
            3'b010:  rdata = {{32{raw[31]}}, raw[31:0]};
            3'b100:  rdata = {56'd0, raw[7:0]};
            3'b101:  rdata = {48'd0, raw[15:0]};
            3'b110:  rdata = {32'd0, raw[31:0]};
            default: rdata = raw;
        endcase
    end

endmodule

// ==== design/dmem_victim.sv ====
/* round-robin replacement state, one way pointer per set
   the cache reads the pointer of the addressed set and strobes fill on refill */
module dmem_victim (
    input  logic           clk,
    input  logic           rst_n,
    input  dmem_pkg::set_t set,
    input  logic           fill,
    output dmem_pkg::way_t way
);
    import dmem_pkg::*;

    way_t ptr [SETS];

    assign way = ptr[set];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                ptr[s] <= '0;
            end
        end else if (fill) begin
            // wrap after the last way
            if (ptr[set] == way_t'(WAYS - 1)) begin
                ptr[set] <= '0;
            end else begin
                ptr[set] <= ptr[set] + 1'b1;
            end
        end
    end

endmodule

// ==== design/dmem_cache.sv ====
/* set-associative write-through L1 data cache with write-allocate
   takes one request at a time, looks it up, refills misses from the line
   memory and answers with a single-cycle response strobe */
module dmem_cache (
    input  logic                 clk,
    input  logic                 rst_n,
    input  dmem_pkg::mem_req_t   req,
    input  logic                 req_valid,
    output dmem_pkg::mem_resp_t  resp,
    output logic                 resp_valid,
    output logic                 busy,
    input  dmem_pkg::blk_addr_t  inv_blk,
    input  logic                 inv_valid,
    output dmem_pkg::line_req_t  l2_req,
    output logic                 l2_req_valid,
    input  dmem_pkg::line_t      l2_rline,
    input  logic                 l2_rvalid
);
    import dmem_pkg::*;

    cache_state_e state;
    cache_state_e state_next;

    // registered request and its address fields
    mem_req_t  req_r;
    blk_addr_t req_blk;
    tag_t      req_tag;
    set_t      req_set;

    // arrays, indexed by set then way
    line_t           data_mem  [SETS][WAYS];
    tag_t            tag_mem   [SETS][WAYS];
    logic [WAYS-1:0] valid_mem [SETS];

    line_t line_r;
    way_t  way_r;
    logic  fill_r;

    logic  hit;
    way_t  hit_way;
    way_t  victim_way;
    logic  fill;
    logic  hit_store;
    line_t align_line;
    line_t merged;
    logic [63:0] ld_data;
    logic  ld_ma;
    logic  st_ma;

    logic  data_we;
    way_t  data_way;
    line_t data_wline;

    tag_t  inv_tag;
    set_t  inv_set;

    assign req_blk = req_r.addr[OFFS_W +: BLK_W];
    assign req_tag = req_blk[SET_W +: TAG_W];
    assign req_set = req_blk[SET_W-1:0];
    assign inv_tag = inv_blk[SET_W +: TAG_W];
    assign inv_set = inv_blk[SET_W-1:0];

    assign busy = (state != S_READY);

    always_ff @(posedge clk) begin
        if (state == S_READY && req_valid) begin
            req_r <= req;
        end
    end

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (valid_mem[req_set][w] && tag_mem[req_set][w] == req_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    assign fill      = (state == S_FILL) && l2_rvalid;
    assign hit_store = (state == S_RESP) && req_r.wr && !fill_r;

    // during refill the merge works on the incoming line
    assign align_line = (state == S_FILL) ? l2_rline : line_r;

    dmem_align u_align (
        .req    (req_r),
        .line   (align_line),
        .merged (merged),
        .rdata  (ld_data),
        .ld_ma  (ld_ma),
        .st_ma  (st_ma)
    );

    dmem_victim u_victim (
        .clk   (clk),
        .rst_n (rst_n),
        .set   (req_set),
        .fill  (fill),
        .way   (victim_way)
    );

    always_comb begin
        state_next = state;
        case (state)
            S_READY: begin
                if (req_valid) begin
                    state_next = S_LOOKUP;
                end
            end
            S_LOOKUP: begin
                if (ld_ma || st_ma) begin
                    state_next = S_READY;
                end else if (hit) begin
                    state_next = S_RESP;
                end else begin
                    state_next = S_FETCH;
                end
            end
            S_FETCH: state_next = S_FILL;
            S_FILL: begin
                if (l2_rvalid) begin
                    state_next = S_RESP;
                end
            end
            default: state_next = S_READY;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= S_READY;
            resp_valid <= 1'b0;
            fill_r     <= 1'b0;
        end else begin
            state      <= state_next;
            resp_valid <= (state == S_LOOKUP && (ld_ma || st_ma)) || state == S_RESP;
            if (state == S_LOOKUP) begin
                fill_r <= 1'b0;
            end else if (fill) begin
                fill_r <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_LOOKUP) begin
            resp.rdata <= '0;
            resp.ld_ma <= ld_ma;
            resp.st_ma <= st_ma;
        end else if (state == S_RESP) begin
            resp.rdata <= req_r.wr ? 64'd0 : ld_data;
            resp.ld_ma <= 1'b0;
            resp.st_ma <= 1'b0;
        end
    end

    // line read for the response stage
    always_ff @(posedge clk) begin
        if (state == S_LOOKUP) begin
            line_r <= data_mem[req_set][hit_way];
            way_r  <= hit_way;
        end else if (fill) begin
            line_r <= l2_rline;
        end
    end

    // a store lands merged, on refill as well as on a hit
    assign data_we    = fill || hit_store;
    assign data_way   = fill ? victim_way : way_r;
    assign data_wline = req_r.wr ? merged : l2_rline;

    always_ff @(posedge clk) begin
        if (data_we) begin
            data_mem[req_set][data_way] <= data_wline;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < SETS; s++) begin
                valid_mem[s] <= '0;
                for (int w = 0; w < WAYS; w++) begin
                    tag_mem[s][w] <= '0;
                end
            end
        end else if (fill) begin
            tag_mem[req_set][victim_way]   <= req_tag;
            valid_mem[req_set][victim_way] <= 1'b1;
        end else if (inv_valid) begin
            for (int w = 0; w < WAYS; w++) begin
                if (tag_mem[inv_set][w] == inv_tag) begin
                    valid_mem[inv_set][w] <= 1'b0;
                end
            end
        end
    end

    // read in S_FETCH, write-through on store hit or store refill
    assign l2_req_valid = (state == S_FETCH) || (fill && req_r.wr) || hit_store;

    always_comb begin
        l2_req.blk   = req_blk;
        l2_req.wr    = (state != S_FETCH);
        l2_req.wline = merged;
    end

endmodule

// ==== design/l2_line_mem.sv ====
/* backing line memory behind the L1 data cache
   reads return a whole line L2_LATENCY cycles after the strobe,
   writes take effect at the edge of their strobe */
module l2_line_mem (
    input  logic                clk,
    input  logic                rst_n,
    input  dmem_pkg::line_req_t l2_req,
    input  logic                l2_req_valid,
    output dmem_pkg::line_t     l2_rline,
    output logic                l2_rvalid
);
    import dmem_pkg::*;

    line_t mem     [L2_LINES];
    line_t rd_pipe [L2_LATENCY];
    logic [L2_LATENCY-1:0] vld_pipe;
    logic  rd_req;

    // each byte starts out as the low byte of its own address
    initial begin
        for (int i = 0; i < L2_LINES; i++) begin
            for (int b = 0; b < LINE_BYTES; b++) begin
                mem[i][8*b +: 8] = 8'(i * LINE_BYTES + b);
            end
        end
    end

    assign rd_req = l2_req_valid && !l2_req.wr;

    always @(posedge clk) begin
        if (l2_req_valid && l2_req.wr) begin
            mem[l2_req.blk] <= l2_req.wline;
        end
    end

    // several reads may be in flight
    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_pipe[0] <= mem[l2_req.blk];
        end
        for (int i = 1; i < L2_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vld_pipe <= '0;
        end else begin
            vld_pipe <= {vld_pipe[L2_LATENCY-2:0], rd_req};
        end
    end

    assign l2_rline  = rd_pipe[L2_LATENCY-1];
    assign l2_rvalid = vld_pipe[L2_LATENCY-1];

endmodule

// ==== design/dmem_subsys.sv ====
/* data-memory subsystem top, the L1 data cache with its backing
   line memory; the load/store unit talks to the request side only */
module dmem_subsys (
    input  logic                clk,
    input  logic                rst_n,
    input  dmem_pkg::mem_req_t  req,
    input  logic                req_valid,
    output logic                busy,
    output dmem_pkg::mem_resp_t resp,
    output logic                resp_valid,
    input  dmem_pkg::blk_addr_t inv_blk,
    input  logic                inv_valid
);
    import dmem_pkg::*;

    line_req_t l2_req;
    logic      l2_req_valid;
    line_t     l2_rline;
    logic      l2_rvalid;

    dmem_cache u_cache (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .req_valid    (req_valid),
        .resp         (resp),
        .resp_valid   (resp_valid),
        .busy         (busy),
        .inv_blk      (inv_blk),
        .inv_valid    (inv_valid),
        .l2_req       (l2_req),
        .l2_req_valid (l2_req_valid),
        .l2_rline     (l2_rline),
        .l2_rvalid    (l2_rvalid)
    );

    l2_line_mem u_l2 (
        .clk          (clk),
        .rst_n        (rst_n),
        .l2_req       (l2_req),
        .l2_req_valid (l2_req_valid),
        .l2_rline     (l2_rline),
        .l2_rvalid    (l2_rvalid)
    );

endmodule

// ==== dv/tb_clkgen.sv ====
/* free-running testbench clock with a 40 ns period, starting low
   instantiated once by the testbench top */
module tb_clkgen (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
    end

    // half period
    always begin
        #20;
        clk = ~clk;
    end

endmodule

// ==== dv/dmem_checker.sv ====
/* handshake and timing assertions for the L1 data cache
   bound into every dmem_cache instance */
module dmem_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                req_valid,
    input logic                busy,
    input logic                resp_valid,
    input dmem_pkg::line_req_t l2_req,
    input logic                l2_req_valid,
    input logic                l2_rvalid
);
    timeunit 1ns;
    timeprecision 1ps;
    import dmem_pkg::*;

    logic l2_rd;

    assign l2_rd = l2_req_valid && !l2_req.wr;

    // one request at a time
    a_req_idle: assert property (@(posedge clk) disable iff (!rst_n) req_valid |-> !busy)
        else $error("request strobe while the cache is busy");

    a_resp_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid |=> !resp_valid)
        else $error("response strobe longer than one cycle");

    // line memory read latency checked in both directions
    a_l2_latency: assert property (@(posedge clk) disable iff (!rst_n)
        l2_rd |-> ##L2_LATENCY l2_rvalid)
        else $error("line read data did not arrive on time");

    a_l2_no_spurious: assert property (@(posedge clk) disable iff (!rst_n)
        l2_rvalid |-> $past(l2_rd, L2_LATENCY))
        else $error("line read data without a matching read strobe");

endmodule

bind dmem_cache dmem_checker u_checker (
    .clk          (clk),
    .rst_n        (rst_n),
    .req_valid    (req_valid),
    .busy         (busy),
    .resp_valid   (resp_valid),
    .l2_req       (l2_req),
    .l2_req_valid (l2_req_valid),
    .l2_rvalid    (l2_rvalid)
);

// ==== dv/dmem_tb.sv ====
/* testbench for the data-memory subsystem, top module of the simulation
   directed loads, stores, misaligned accesses and invalidates, then a random mix;
   a byte-level reference predicts data, flags and latency of every response */
module dmem_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import dmem_pkg::*;

    typedef struct packed {
        addr_t       addr;
        logic [63:0] rdata;
        logic        ld_ma;
        logic        st_ma;
        logic        load;
        logic [3:0]  lat;
    } expect_t;

    logic      clk;
    logic      rst_n;
    mem_req_t  req;
    logic      req_valid;
    logic      busy;
    mem_resp_t resp;
    logic      resp_valid;
    blk_addr_t inv_blk;
    logic      inv_valid;

    // flat byte image of the line memory and a shadow of the cache tags
    logic [7:0]      ref_mem   [L2_LINES * LINE_BYTES];
    tag_t            model_tag [SETS][WAYS];
    logic [WAYS-1:0] model_vld [SETS];
    way_t            model_ptr [SETS];

    expect_t     exp_q [$];
    expect_t     cmp_exp;
    logic        pending;
    int          cyc;
    int          checks;
    int          errors;
    int          timeouts;
    logic [31:0] lcg_state;

    tb_clkgen u_clk (.clk(clk));

    dmem_subsys uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .req        (req),
        .req_valid  (req_valid),
        .busy       (busy),
        .resp       (resp),
        .resp_valid (resp_valid),
        .inv_blk    (inv_blk),
        .inv_valid  (inv_valid)
    );

    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    // expected response of one access; updates the byte image and the tag shadow
    function automatic expect_t ref_access(input addr_t addr, input acc_len_t len,
                                           input logic [63:0] wdata, input logic wr);
        expect_t                  e;
        int                       size;
        logic [OFFS_W+BLK_W-1:0]  base;
        blk_addr_t                blk;
        set_t                     s;
        tag_t                     t;
        logic                     hit;
        size   = 1 << len[1:0];
        base   = addr[OFFS_W+BLK_W-1:0];
        blk    = addr[OFFS_W +: BLK_W];
        s      = blk[SET_W-1:0];
        t      = blk[BLK_W-1:SET_W];
        e      = '0;
        e.addr = addr;
        e.load = !wr;
        if (int'(addr[OFFS_W-1:0]) % size != 0) begin
            e.ld_ma = !wr;
            e.st_ma = wr;
            e.lat   = 4'd1;
        end else begin
            hit = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                if (model_vld[s][w] && model_tag[s][w] == t) begin
                    hit = 1'b1;
                end
            end
            if (hit) begin
                e.lat = 4'd2;
            end else begin
                // refill replaces the way under the set's pointer
                e.lat = 4'(L2_LATENCY + 3);
                model_tag[s][model_ptr[s]] = t;
                model_vld[s][model_ptr[s]] = 1'b1;
                model_ptr[s] = way_t'((int'(model_ptr[s]) + 1) % WAYS);
            end
            for (int k = 0; k < size; k++) begin
                if (wr) begin
                    ref_mem[base + k[OFFS_W+BLK_W-1:0]] = wdata[8*k +: 8];
                end else begin
                    e.rdata[8*k +: 8] = ref_mem[base + k[OFFS_W+BLK_W-1:0]];
                end
            end
            // sign bits above the loaded bytes
            if (!wr && !len[2]) begin
                for (int b = 8 * size; b < 64; b++) begin
                    e.rdata[b] = e.rdata[8 * size - 1];
                end
            end
        end
        return e;
    endfunction

    task automatic finish_run();
        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0 && checks > 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic access_mem(input addr_t addr, input acc_len_t len,
                              input logic [63:0] wdata, input logic wr);
        int   waited;
        logic seen;
        // a stuck DUT ends the stimulus
        if (timeouts != 0) begin
            return;
        end
        waited = 0;
        while (busy && waited < 20) begin
            @(posedge clk);
            #2;
            waited++;
        end
        if (busy) begin
            $display("timeout: busy stayed high, no new request could be sent");
            timeouts++;
        end else begin
            exp_q.push_back(ref_access(addr, len, wdata, wr));
            req.addr  = addr;
            req.len   = len;
            req.wdata = wdata;
            req.wr    = wr;
            req_valid = 1'b1;
            @(posedge clk);
            #2;
            req_valid = 1'b0;
            waited    = 0;
            seen      = 1'b0;
            while (!seen && waited < 20) begin
                @(negedge clk);
                seen = resp_valid;
                waited++;
            end
            if (!seen) begin
                $display("timeout: no response to the access at %h", addr);
                timeouts++;
            end else begin
                @(posedge clk);
                #2;
            end
        end
    endtask

    task automatic invalidate_line(input addr_t addr);
        blk_addr_t blk;
        blk = addr[OFFS_W +: BLK_W];
        for (int w = 0; w < WAYS; w++) begin
            if (model_tag[blk[SET_W-1:0]][w] == blk[BLK_W-1:SET_W]) begin
                model_vld[blk[SET_W-1:0]][w] = 1'b0;
            end
        end
        inv_blk   = blk;
        inv_valid = 1'b1;
        @(posedge clk);
        #2;
        inv_valid = 1'b0;
    endtask

    // response checks sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (req_valid) begin
                pending = 1'b1;
                cyc     = 0;
            end else if (resp_valid) begin
                if (!pending || exp_q.size() == 0) begin
                    $display("response strobe arrived with no request outstanding");
                    errors++;
                end else begin
                    cmp_exp = exp_q.pop_front();
                    checks++;
                    if (busy) begin
                        $display("[FAIL] %0t: busy still high with the response", $time);
                        errors++;
                    end
                    if (cyc != int'(cmp_exp.lat)) begin
                        $display("[FAIL] %0t: access %h answered after %0d cycles, expected %0d",
                                 $time, cmp_exp.addr, cyc, cmp_exp.lat);
                        errors++;
                    end
                    if (resp.ld_ma != cmp_exp.ld_ma || resp.st_ma != cmp_exp.st_ma) begin
                        $display("[FAIL] %0t: access %h flags ld_ma %b st_ma %b, expected %b %b",
                                 $time, cmp_exp.addr, resp.ld_ma, resp.st_ma,
                                 cmp_exp.ld_ma, cmp_exp.st_ma);
                        errors++;
                    end
                    if (cmp_exp.load && !cmp_exp.ld_ma && resp.rdata != cmp_exp.rdata) begin
                        $display("[FAIL] %0t: load %h returned %h, expected %h",
                                 $time, cmp_exp.addr, resp.rdata, cmp_exp.rdata);
                        errors++;
                    end
                end
                pending = 1'b0;
            end else if (pending) begin
                if (!busy) begin
                    $display("[FAIL] %0t: busy low while a request is outstanding", $time);
                    errors++;
                end
                cyc++;
            end
        end
    end

    initial begin
        logic [15:0] r1;
        logic [15:0] r2;
        addr_t       a;
        acc_len_t    l;
        rst_n     = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        inv_blk   = '0;
        inv_valid = 1'b0;
        pending   = 1'b0;
        cyc       = 0;
        checks    = 0;
        errors    = 0;
        timeouts  = 0;
        lcg_state = 32'd56553;
        // each byte starts as the low byte of its own address
        for (int i = 0; i < L2_LINES * LINE_BYTES; i++) begin
            ref_mem[i] = 8'(i);
        end
        for (int s = 0; s < SETS; s++) begin
            model_vld[s] = '0;
            model_ptr[s] = '0;
            for (int w = 0; w < WAYS; w++) begin
                model_tag[s][w] = '0;
            end
        end
        for (int c = 0; c < 10; c++) begin
            @(posedge clk);
        end
        #2;
        rst_n = 1'b1;

        // untouched memory in every size and sign mode with negative and positive bytes
        for (int n = 0; n < 8; n++) begin
            access_mem(64'h0f8, acc_len_t'(n), 64'd0, 1'b0);
            access_mem(64'h040, acc_len_t'(n), 64'd0, 1'b0);
        end

        // store miss allocates, then overlapping loads and a store hit
        access_mem(64'h300, 3'd3, 64'h0123_4567_89ab_cdef, 1'b1);
        access_mem(64'h300, 3'd0, 64'd0, 1'b0);
        access_mem(64'h302, 3'd1, 64'd0, 1'b0);
        access_mem(64'h304, 3'd2, 64'd0, 1'b0);
        access_mem(64'h306, 3'd5, 64'd0, 1'b0);
        access_mem(64'h300, 3'd3, 64'd0, 1'b0);
        access_mem(64'h305, 3'd0, 64'h0000_0000_0000_0080, 1'b1);
        access_mem(64'h304, 3'd2, 64'd0, 1'b0);
        access_mem(64'h304, 3'd6, 64'd0, 1'b0);
        access_mem(64'h31e, 3'd1, 64'h0000_0000_0000_a55a, 1'b1);
        access_mem(64'h318, 3'd3, 64'd0, 1'b0);

        // five lines into set 5 so the fifth evicts the oldest
        for (int k = 0; k < 5; k++) begin
            access_mem(64'h8a0 + 64'(k * 256), 3'd3, 64'd0, 1'b0);
        end
        access_mem(64'h8a0, 3'd3, 64'd0, 1'b0);
        access_mem(64'haa0, 3'd3, 64'd0, 1'b0);
        access_mem(64'h9a0, 3'd3, 64'd0, 1'b0);

        // misaligned accesses leave memory unchanged
        access_mem(64'h301, 3'd1, 64'd0, 1'b0);
        access_mem(64'h302, 3'd2, 64'hffff_ffff_ffff_ffff, 1'b1);
        access_mem(64'h304, 3'd3, 64'hffff_ffff_ffff_ffff, 1'b1);
        access_mem(64'h300, 3'd3, 64'd0, 1'b0);

        // invalidated line misses but keeps the written-through data
        invalidate_line(64'h300);
        access_mem(64'h300, 3'd3, 64'd0, 1'b0);
        access_mem(64'h318, 3'd3, 64'd0, 1'b0);

        // random mix in a 4 KB window
        for (int n = 0; n < 300; n++) begin
            r1 = lcg_next();
            r2 = lcg_next();
            a  = 64'h1000 + 64'(r2[11:0]);
            l  = r1[2:0];
            if (r1[15:13] != 3'd0) begin
                a = (a >> l[1:0]) << l[1:0];
            end
            if (r2[15:12] == 4'hf) begin
                invalidate_line(a);
            end
            access_mem(a, l, {lcg_next(), lcg_next(), lcg_next(), lcg_next()}, r1[3]);
        end

        finish_run();
    end

endmodule

// ==== tb.f ====
design/dmem_pkg.sv
design/dmem_align.sv
design/dmem_victim.sv
design/dmem_cache.sv
design/l2_line_mem.sv
design/dmem_subsys.sv
dv/tb_clkgen.sv
dv/dmem_checker.sv
dv/dmem_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the data-memory subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module dmem_tb -f tb.f -o dmem_sim

out=$(./obj_dir/dmem_sim) || true
echo "$out"
echo "$out" | grep -qx "TESTBENCH PASSED"
